// ==== Makefile ====
TOP = spu_tb

.PHONY: run build lint clean

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -Mdir obj_dir -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

// ==== logic/spu_core.sv ====
module spu_core import spu_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic     s_wb_clk_i,
    input  logic     s_wb_rst_i,

    input  logic     start_i,
    output logic     done_o,

    spu_core_if.core mem
);

    localparam int BYTES = $bits(wb_dat_t) / 8;

    core_state_t              state_q;
    logic [MEM_ADDR_BITS-1:0] addr_q;
    logic [MEM_LATENCY-1:0]   vld_q;
    logic [MEM_ADDR_BITS-1:0] adr_pipe_q [MEM_LATENCY];

    wb_dat_t                  sum_d;
    wb_dat_t                  xor_d;

    // --------------------------------------------------
    //  address sequencer
    // --------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            state_q <= IDLE;
            addr_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        addr_q  <= '0;
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    addr_q <= addr_q + MEM_ADDR_BITS'(1);
                    if (addr_q == '1) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    // wait for the last items in flight
                    if (vld_q == '0) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign mem.rd_addr = addr_q;

    // --------------------------------------------------
    //  alignment with read latency
    // --------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= (state_q == RUN);
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        adr_pipe_q[0] <= addr_q;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            adr_pipe_q[i] <= adr_pipe_q[i-1];
        end
    end

    // lane-wise sum, each byte wraps on its own
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            sum_d[b*8 +: 8] = mem.rd0_data[b*8 +: 8] + mem.rd1_data[b*8 +: 8];
        end
        xor_d = mem.rd0_data ^ mem.rd1_data;
    end

    assign mem.wr_en    = vld_q[MEM_LATENCY-1];
    assign mem.wr_addr  = adr_pipe_q[MEM_LATENCY-1];
    assign mem.wr2_data = sum_d;
    assign mem.wr3_data = xor_d;

    // pulse in the cycle after the last write
    assign done_o = (state_q == DRAIN) && (vld_q == '0);

endmodule

// ==== logic/spu_core_if.sv ====
interface spu_core_if import spu_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10
) ();

    // read side, source banks 0 and 1
    logic [MEM_ADDR_BITS-1:0] rd_addr;
    wb_dat_t                  rd0_data;
    wb_dat_t                  rd1_data;

    // write side, result banks 2 and 3
    logic                     wr_en;
    logic [MEM_ADDR_BITS-1:0] wr_addr;
    wb_dat_t                  wr2_data;
    wb_dat_t                  wr3_data;

    modport core (
        output rd_addr,
        input  rd0_data,
        input  rd1_data,
        output wr_en,
        output wr_addr,
        output wr2_data,
        output wr3_data
    );

    modport bank (
        input  rd_addr,
        output rd0_data,
        output rd1_data,
        input  wr_en,
        input  wr_addr,
        input  wr2_data,
        input  wr3_data
    );

endinterface

// ==== logic/spu_mem_bank.sv ====
module spu_mem_bank import spu_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10,
    // banks 0 and 1 feed the core, banks 2 and 3 take its results
    parameter int BANK_ID       = 0
) (
    input  logic                     s_wb_clk_i,
    input  logic                     s_wb_rst_i,

    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [MEM_ADDR_BITS-1:0] adr_i,
    input  wb_dat_t                  dat_i,
    input  wb_sel_t                  sel_i,
    output wb_dat_t                  dat_o,
    output logic                     ack_o,

    spu_core_if.bank                 core
);

    localparam int DEPTH    = 2 ** MEM_ADDR_BITS;
    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    wb_dat_t                  mem_q [DEPTH];
    wb_dat_t                  bus_pipe_q [MEM_LATENCY];
    logic [CNT_BITS-1:0]      lat_cnt_q;

    logic                     core_we;
    logic [MEM_ADDR_BITS-1:0] core_waddr;
    wb_dat_t                  core_wdata;

    // --------------------------------------------------
    //  bus port
    // --------------------------------------------------

    // counts the cycles of the current request, restarts after ack
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            lat_cnt_q <= '0;
        end else if (!stb_i || ack_o) begin
            lat_cnt_q <= '0;
        end else begin
            lat_cnt_q <= lat_cnt_q + CNT_BITS'(1);
        end
    end

    assign ack_o = stb_i && (lat_cnt_q == CNT_BITS'(MEM_LATENCY));

    always_ff @(posedge s_wb_clk_i) begin
        bus_pipe_q[0] <= mem_q[adr_i];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            bus_pipe_q[i] <= bus_pipe_q[i-1];
        end
    end

    assign dat_o = bus_pipe_q[MEM_LATENCY-1];

    // bus commits at the acking edge, core writes whole words
    always_ff @(posedge s_wb_clk_i) begin
        if (stb_i && we_i && ack_o) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
                if (sel_i[b]) begin
                    mem_q[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
                end
            end
        end
        if (core_we) begin
            mem_q[core_waddr] <= core_wdata;
        end
    end

    // --------------------------------------------------
    //  core port
    // --------------------------------------------------

    if (BANK_ID < 2) begin : g_read
        wb_dat_t core_pipe_q [MEM_LATENCY];

        always_ff @(posedge s_wb_clk_i) begin
            core_pipe_q[0] <= mem_q[core.rd_addr];
            for (int i = 1; i < MEM_LATENCY; i++) begin
                core_pipe_q[i] <= core_pipe_q[i-1];
            end
        end

        if (BANK_ID == 0) begin : g_src_a
            assign core.rd0_data = core_pipe_q[MEM_LATENCY-1];
        end else begin : g_src_b
            assign core.rd1_data = core_pipe_q[MEM_LATENCY-1];
        end

        assign core_we    = 1'b0;
        assign core_waddr = '0;
        assign core_wdata = '0;
    end else begin : g_write
        assign core_we    = core.wr_en;
        assign core_waddr = core.wr_addr;
        assign core_wdata = (BANK_ID == 2) ? core.wr2_data : core.wr3_data;
    end

endmodule

// ==== logic/spu_pkg.sv ====
package spu_pkg;

    // --------------------------------------------------
    //  bus and memory words
    // --------------------------------------------------

    typedef logic [63:0] wb_dat_t;
    typedef logic [7:0]  wb_sel_t;

    // read latency of a bank, bus port and core port alike
    localparam int MEM_LATENCY = 2;

    // --------------------------------------------------
    //  address map
    // --------------------------------------------------

    // top 3 address bits select the block
    typedef logic [2:0] region_t;

    localparam region_t REGION_REGS = 3'd0;
    localparam region_t REGION_MEM0 = 3'd4;
    localparam region_t REGION_MEM1 = 3'd5;
    localparam region_t REGION_MEM2 = 3'd6;
    localparam region_t REGION_MEM3 = 3'd7;

    typedef logic [3:0] reg_adr_t;

    localparam reg_adr_t ADR_START   = 4'h0;
    localparam reg_adr_t ADR_DONE    = 4'h1;
    localparam reg_adr_t ADR_REPEAT  = 4'h2;
    localparam reg_adr_t ADR_TIME    = 4'h3;
    localparam reg_adr_t ADR_COUNTER = 4'h4;

    // elapsed time and free-running counter
    typedef logic [31:0] cycle_t;

    // --------------------------------------------------
    //  core sequencer
    // --------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } core_state_t;

endpackage

// ==== logic/spu_regs.sv ====
module spu_regs import spu_pkg::*; (
    input  logic     s_wb_clk_i,
    input  logic     s_wb_rst_i,

    input  logic     stb_i,
    input  logic     we_i,
    input  reg_adr_t adr_i,
    input  wb_dat_t  dat_i,
    input  wb_sel_t  sel_i,
    output wb_dat_t  dat_o,

    output logic     core_start_o,
    input  logic     core_done_i
);

    logic   start_q;
    logic   done_q;
    logic   repeat_q;
    cycle_t time_q;
    cycle_t counter_q;

    logic   wr_en;
    logic   start_nxt;

    // only bit 0 of each flag is writable, so only byte 0 matters
    assign wr_en = stb_i && we_i && sel_i[0];

    // --------------------------------------------------
    //  start sequencing
    // --------------------------------------------------

    // repeat restarts on done, a host write wins
    always_comb begin
        start_nxt = 1'b0;
        if (core_done_i) begin
            start_nxt = repeat_q;
        end
        if (wr_en && (adr_i == ADR_START)) begin
            start_nxt = dat_i[0];
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            repeat_q  <= 1'b0;
            time_q    <= '0;
            counter_q <= '0;
        end else begin
            // single cycle unless reloaded
            start_q <= start_nxt;

            if (core_done_i) begin
                done_q <= 1'b1;
                time_q <= counter_q;
            end

            if (wr_en && (adr_i == ADR_DONE)) begin
                done_q <= dat_i[0];
            end
            if (wr_en && (adr_i == ADR_REPEAT)) begin
                repeat_q <= dat_i[0];
            end

            // counter is zero in the cycle start is high
            if (start_nxt) begin
                done_q    <= 1'b0;
                counter_q <= '0;
            end else begin
                counter_q <= counter_q + cycle_t'(1);
            end
        end
    end

    assign core_start_o = start_q;

    // --------------------------------------------------
    //  read mux
    // --------------------------------------------------

    always_comb begin
        dat_o = '0;
        case (adr_i)
            ADR_START:   dat_o = wb_dat_t'(start_q);
            ADR_DONE:    dat_o = wb_dat_t'(done_q);
            ADR_REPEAT:  dat_o = wb_dat_t'(repeat_q);
            ADR_TIME:    dat_o = wb_dat_t'(time_q);
            ADR_COUNTER: dat_o = wb_dat_t'(counter_q);
            default: ;
        endcase
    end

endmodule

// ==== logic/spu_top.sv ====
module spu_top import spu_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                     s_wb_clk_i,
    input  logic                     s_wb_rst_i,
    input  logic [MEM_ADDR_BITS+2:0] s_wb_adr_i,
    input  wb_dat_t                  s_wb_dat_i,
    output wb_dat_t                  s_wb_dat_o,
    input  logic                     s_wb_we_i,
    input  wb_sel_t                  s_wb_sel_i,
    input  logic                     s_wb_stb_i,
    output logic                     s_wb_ack_o
);

    region_t    region;
    logic       reg_stb;
    wb_dat_t    reg_dat;
    logic [3:0] mem_stb;
    wb_dat_t    mem_dat [4];
    logic [3:0] mem_ack;

    logic       core_start;
    logic       core_done;

    spu_core_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) core_if ();

    // --------------------------------------------------
    //  region decode
    // --------------------------------------------------

    assign region = s_wb_adr_i[MEM_ADDR_BITS +: $bits(region_t)];

    always_comb begin
        reg_stb = 1'b0;
        mem_stb = '0;
        if (s_wb_stb_i) begin
            case (region)
                REGION_REGS: reg_stb    = 1'b1;
                REGION_MEM0: mem_stb[0] = 1'b1;
                REGION_MEM1: mem_stb[1] = 1'b1;
                REGION_MEM2: mem_stb[2] = 1'b1;
                REGION_MEM3: mem_stb[3] = 1'b1;
                default: ;
            endcase
        end
    end

    // unmapped: ack follows stb, data stays zero
    always_comb begin
        s_wb_dat_o = '0;
        s_wb_ack_o = s_wb_stb_i;
        if (reg_stb) begin
            s_wb_dat_o = reg_dat;
            s_wb_ack_o = reg_stb;
        end
        for (int i = 0; i < 4; i++) begin
            if (mem_stb[i]) begin
                s_wb_dat_o = mem_dat[i];
                s_wb_ack_o = mem_ack[i];
            end
        end
    end

    // --------------------------------------------------
    //  blocks
    // --------------------------------------------------

    spu_regs u_regs (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .stb_i        (reg_stb),
        .we_i         (s_wb_we_i),
        .adr_i        (reg_adr_t'(s_wb_adr_i[$bits(reg_adr_t)-1:0])),
        .dat_i        (s_wb_dat_i),
        .sel_i        (s_wb_sel_i),
        .dat_o        (reg_dat),
        .core_start_o (core_start),
        .core_done_i  (core_done)
    );

    for (genvar i = 0; i < 4; i++) begin : g_bank
        spu_mem_bank #(
            .MEM_ADDR_BITS (MEM_ADDR_BITS),
            .BANK_ID       (i)
        ) u_bank (
            .s_wb_clk_i (s_wb_clk_i),
            .s_wb_rst_i (s_wb_rst_i),
            .stb_i      (mem_stb[i]),
            .we_i       (s_wb_we_i),
            .adr_i      (s_wb_adr_i[MEM_ADDR_BITS-1:0]),
            .dat_i      (s_wb_dat_i),
            .sel_i      (s_wb_sel_i),
            .dat_o      (mem_dat[i]),
            .ack_o      (mem_ack[i]),
            .core       (core_if)
        );
    end

    spu_core #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_core (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .start_i    (core_start),
        .done_o     (core_done),
        .mem        (core_if)
    );

endmodule

// ==== sim.f ====
logic/spu_pkg.sv
logic/spu_core_if.sv
logic/spu_regs.sv
logic/spu_mem_bank.sv
logic/spu_core.sv
logic/spu_top.sv
tb/spu_chk.sv
tb/spu_tb.sv

// ==== tb/spu_chk.sv ====
module spu_chk import spu_pkg::*; (
    input logic        clk_i,
    input logic        rst_i,
    input logic        stb_i,
    input logic        ack_i,
    input logic        done_i,
    input logic        wr_en_i,
    input core_state_t state_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    //  bus and core protocol
    // --------------------------------------------------

    ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> stb_i)
        else $error("bus ack seen without stb");

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
        else $error("core done high for two cycles");

    no_write_idle: assert property (@(posedge clk_i) disable iff (rst_i)
                                    wr_en_i |-> (state_i != IDLE))
        else $error("core writes a result while idle");

endmodule

bind spu_top spu_chk u_chk (
    .clk_i   (s_wb_clk_i),
    .rst_i   (s_wb_rst_i),
    .stb_i   (s_wb_stb_i),
    .ack_i   (s_wb_ack_o),
    .done_i  (core_done),
    .wr_en_i (core_if.wr_en),
    .state_i (u_core.state_q)
);

// ==== tb/spu_tb.sv ====
module spu_tb import spu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_BITS  = 6;
    localparam int WORDS      = 2 ** ADDR_BITS;
    localparam int RUN_TIME   = WORDS + MEM_LATENCY + 1;
    localparam int BUS_LIMIT  = 16;
    localparam int POLL_LIMIT = 200;

    typedef logic [ADDR_BITS+2:0] bus_adr_t;

    logic     clk;
    logic     rst;
    bus_adr_t adr;
    wb_dat_t  dat_w;
    wb_dat_t  dat_r;
    logic     we;
    wb_sel_t  sel;
    logic     stb;
    logic     ack;

    // expected contents of the four banks
    wb_dat_t  model [4][WORDS];
    int       mismatches;
    int       timeouts;

    spu_top #(.MEM_ADDR_BITS(ADDR_BITS)) uut (
        .s_wb_clk_i (clk),
        .s_wb_rst_i (rst),
        .s_wb_adr_i (adr),
        .s_wb_dat_i (dat_w),
        .s_wb_dat_o (dat_r),
        .s_wb_we_i  (we),
        .s_wb_sel_i (sel),
        .s_wb_stb_i (stb),
        .s_wb_ack_o (ack)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    //  address map and reference rules
    // --------------------------------------------------

    function automatic bus_adr_t reg_addr(input reg_adr_t off);
        return {REGION_REGS, ADDR_BITS'(off)};
    endfunction

    function automatic bus_adr_t mem_addr(input int bank, input int word);
        region_t r;
        r = region_t'(int'(REGION_MEM0) + bank);
        return {r, ADDR_BITS'(word)};
    endfunction

    function automatic wb_dat_t merge_bytes(input wb_dat_t old, input wb_dat_t d,
                                            input wb_sel_t s);
        wb_dat_t r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (s[b]) begin
                r[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // each byte lane wraps on its own
    function automatic wb_dat_t byte_sum(input wb_dat_t a, input wb_dat_t b);
        wb_dat_t r;
        for (int i = 0; i < 8; i++) begin
            r[i*8 +: 8] = 8'((a[i*8 +: 8] + b[i*8 +: 8]) % 256);
        end
        return r;
    endfunction

    // --------------------------------------------------
    //  bus access, called at 1 ns after a rising edge
    // --------------------------------------------------

    task automatic wb_transfer(input bus_adr_t a, input logic w, input wb_dat_t d,
                               input wb_sel_t s, output wb_dat_t q);
        int n;
        adr   = a;
        we    = w;
        dat_w = d;
        sel   = s;
        stb   = 1'b1;
        q     = '0;
        n     = 0;
        @(negedge clk);
        while (!ack && n < BUS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            q = dat_r;
        end else begin
            timeouts++;
            $display("no ack from the DUT within %0d cycles at address %h", BUS_LIMIT, a);
        end
        @(posedge clk);
        #1;
        stb = 1'b0;
        we  = 1'b0;
        // one idle cycle between requests
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input bus_adr_t a, input wb_dat_t d, input wb_sel_t s);
        wb_dat_t ignored;
        wb_transfer(a, 1'b1, d, s, ignored);
    endtask

    task automatic read_word(input bus_adr_t a, output wb_dat_t q);
        wb_transfer(a, 1'b0, '0, 8'hff, q);
    endtask

    task automatic check_value(input string what, input wb_dat_t expected,
                               input wb_dat_t actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("Fail at %0t ns: s_wb_dat_o (%s) expected %h got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_reg(input reg_adr_t off, input string what, input wb_dat_t expected);
        wb_dat_t q;
        read_word(reg_addr(off), q);
        check_value(what, expected, q);
    endtask

    task automatic compare_mem(input int bank);
        wb_dat_t q;
        for (int w = 0; w < WORDS; w++) begin
            read_word(mem_addr(bank, w), q);
            check_value($sformatf("mem%0d[%0d]", bank, w), model[bank][w], q);
        end
    endtask

    // new random sources, results follow from the rules
    task automatic fill_sources();
        wb_dat_t d;
        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < WORDS; w++) begin
                d = {$urandom, $urandom};
                write_word(mem_addr(m, w), d, 8'hff);
                model[m][w] = d;
            end
        end
        for (int w = 0; w < WORDS; w++) begin
            model[2][w] = byte_sum(model[0][w], model[1][w]);
            model[3][w] = model[0][w] ^ model[1][w];
        end
    endtask

    task automatic wait_done();
        wb_dat_t q;
        int      n;
        n = 0;
        read_word(reg_addr(ADR_DONE), q);
        while (q[0] !== 1'b1 && n < POLL_LIMIT) begin
            read_word(reg_addr(ADR_DONE), q);
            n++;
        end
        if (q[0] !== 1'b1) begin
            timeouts++;
            $display("done never set after %0d polls of the done register", POLL_LIMIT);
        end
    endtask

    // --------------------------------------------------
    //  stimulus
    // --------------------------------------------------

    initial begin
        int      m;
        int      w;
        wb_dat_t d;
        wb_dat_t q;
        wb_dat_t c1;
        wb_dat_t c2;
        wb_sel_t s;

        void'($urandom(41032));
        clk        = 1'b0;
        rst        = 1'b1;
        adr        = '0;
        dat_w      = '0;
        we         = 1'b0;
        sel        = '0;
        stb        = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        // full words first, then random byte selects
        for (m = 0; m < 4; m++) begin
            for (w = 0; w < WORDS; w++) begin
                d = {$urandom, $urandom};
                write_word(mem_addr(m, w), d, 8'hff);
                model[m][w] = d;
            end
        end
        for (int i = 0; i < 150; i++) begin
            m = int'($urandom % 4);
            w = int'($urandom % WORDS);
            d = {$urandom, $urandom};
            s = wb_sel_t'($urandom);
            write_word(mem_addr(m, w), d, s);
            model[m][w] = merge_bytes(model[m][w], d, s);
        end
        for (m = 0; m < 4; m++) begin
            compare_mem(m);
        end

        // single run
        fill_sources();
        write_word(reg_addr(ADR_START), 64'h1, 8'h01);
        check_reg(ADR_START, "start", 64'h0);
        wait_done();
        compare_mem(2);
        compare_mem(3);
        check_reg(ADR_TIME, "time", wb_dat_t'(RUN_TIME));

        read_word(reg_addr(ADR_COUNTER), c1);
        read_word(reg_addr(ADR_COUNTER), c2);
        assert (c2 > c1) else begin
            mismatches++;
            $display("Fail at %0t ns: s_wb_dat_o (counter) expected more than %h got %h",
                     $time, c1, c2);
        end

        // byte 0 not selected, nothing changes
        write_word(reg_addr(ADR_DONE), 64'h0, 8'hfe);
        check_reg(ADR_DONE, "done", 64'h1);
        write_word(reg_addr(ADR_REPEAT), 64'h1, 8'hfe);
        check_reg(ADR_REPEAT, "repeat", 64'h0);

        // repeat mode keeps restarting until cleared
        fill_sources();
        write_word(reg_addr(ADR_REPEAT), 64'h1, 8'h01);
        write_word(reg_addr(ADR_START), 64'h1, 8'h01);
        check_reg(ADR_DONE, "done", 64'h0);
        repeat (2 * RUN_TIME) @(posedge clk);
        #1;
        check_reg(ADR_DONE, "done", 64'h0);
        write_word(reg_addr(ADR_REPEAT), 64'h0, 8'h01);
        wait_done();
        compare_mem(2);
        compare_mem(3);

        // host write clears done
        write_word(reg_addr(ADR_DONE), 64'h0, 8'h01);
        check_reg(ADR_DONE, "done", 64'h0);

        // unmapped regions 1 to 3
        for (int r = 1; r < 4; r++) begin
            w = int'($urandom % WORDS);
            read_word({region_t'(r), ADDR_BITS'(w)}, q);
            check_value($sformatf("region %0d", r), 64'h0, q);
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
